//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tetris.f --top-module tetris_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f tetris.f \
		--top-module tetris_tb -o tetris_sim
	@out="$$(./obj_dir/tetris_sim)"; echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

//--- tb/tetris_tb.sv
`timescale 1ns/1ps
`include "tetris_macros.svh"

module tetris_tb;
    logic               pclk;
    logic               rst;
    logic               start;
    logic               left;
    logic               right;
    logic               drop;
    logic               rotate;
    logic [4:0]         row_sel;
    tetris_pkg::piece_t piece;
    tetris_pkg::piece_t next_piece;
    logic signed [4:0]  piece_x;
    logic [4:0]         piece_y;
    logic [1:0]         piece_rot;
    logic               lock;
    logic               lines_valid;
    logic [2:0]         lines_count;
    logic [19:0]        score;
    logic [9:0]         lines_total;
    logic [3:0]         level;
    logic               game_over;
    logic [9:0]         row_bits;

    logic [31:0]            rng;
    logic [15:0]            m_lfsr;
    logic [`BOARD_COLS-1:0] fld [`BOARD_ROWS]; // model field, row 0 on top
    tetris_pkg::piece_t     m_piece;
    tetris_pkg::piece_t     m_next;
    int                     m_x;
    int                     m_y;
    int                     m_rot;
    int                     m_score;
    int                     m_lines;
    int                     m_level;
    int                     m_cnt;
    logic                   m_over;
    int                     err_value;
    int                     err_timeout;

    tetris_core i_tetris_core (.*);

    initial begin
        pclk = 1'b0;
        forever #5 pclk = ~pclk;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic tetris_pkg::piece_t take_piece();
        m_lfsr = m_lfsr[0] ? ((m_lfsr >> 1) ^ `LFSR_TAPS) : (m_lfsr >> 1);
        if (m_lfsr[2:0] == 3'd7)
            return tetris_pkg::PIECE_I;
        return tetris_pkg::piece_t'(m_lfsr[2:0]);
    endfunction

    // returns col * 4 + row of cell k, built from the spawn shape by quarter turns
    function automatic int cell_offset(input tetris_pkg::piece_t p, input int rot, input int k);
        int c [4];
        int r [4];
        int box;
        int cc;
        int rr;
        int t;
        case (p)
            tetris_pkg::PIECE_I: begin
                c = '{0, 1, 2, 3};
                r = '{1, 1, 1, 1};
            end
            tetris_pkg::PIECE_O: begin
                c = '{1, 2, 1, 2};
                r = '{0, 0, 1, 1};
            end
            tetris_pkg::PIECE_T: begin
                c = '{1, 0, 1, 2};
                r = '{0, 1, 1, 1};
            end
            tetris_pkg::PIECE_S: begin
                c = '{1, 2, 0, 1};
                r = '{0, 0, 1, 1};
            end
            tetris_pkg::PIECE_Z: begin
                c = '{0, 1, 1, 2};
                r = '{0, 0, 1, 1};
            end
            tetris_pkg::PIECE_J: begin
                c = '{0, 0, 1, 2};
                r = '{0, 1, 1, 1};
            end
            default: begin
                c = '{2, 0, 1, 2};
                r = '{0, 1, 1, 1};
            end
        endcase
        box = (p == tetris_pkg::PIECE_I) ? 4 : 3;
        cc = c[k];
        rr = r[k];
        if (p != tetris_pkg::PIECE_O) begin
            for (int i = 0; i < rot; i++) begin
                t = cc;
                cc = box - 1 - rr; // clockwise turn inside the box
                rr = t;
            end
        end
        return cc * 4 + rr;
    endfunction

    function automatic logic model_collide(input tetris_pkg::piece_t p, input int x,
                                           input int y, input int rot);
        int off;
        int col;
        int row;
        for (int k = 0; k < 4; k++) begin
            off = cell_offset(p, rot, k);
            col = x + off / 4;
            row = y + off % 4;
            if (col < 0 || col >= `BOARD_COLS || row >= `BOARD_ROWS)
                return 1'b1;
            if (fld[row][col])
                return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic int clear_rows();
        int n;
        int r;
        n = 0;
        r = `BOARD_ROWS - 1;
        while (r >= 0) begin
            if (&fld[r]) begin
                for (int k = r; k > 0; k--) begin
                    fld[k] = fld[k-1];
                end
                fld[0] = '0;
                n++;
            end else begin
                r--;
            end
        end
        return n;
    endfunction

    function automatic int line_points(input int n);
        case (n)
            1: return 40;
            2: return 100;
            3: return 300;
            4: return 1200;
            default: return 0;
        endcase
    endfunction

    task automatic check_piece(input string what, input tetris_pkg::piece_t got,
                               input tetris_pkg::piece_t exp);
        if (got !== exp) begin
            err_value++;
            $display("FAILED %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_pose(input logic signed [4:0] got_x, input logic [4:0] got_y,
                              input logic [1:0] got_rot);
        if (int'(got_x) != m_x || int'(got_y) != m_y || int'(got_rot) != m_rot) begin
            err_value++;
            $display("FAILED %0t: pose x %0d y %0d rot %0d, expected x %0d y %0d rot %0d",
                     $time, got_x, got_y, got_rot, m_x, m_y, m_rot);
        end
    endtask

    task automatic check_row(input int r, input logic [9:0] got, input logic [9:0] exp);
        if (got !== exp) begin
            err_value++;
            $display("FAILED %0t: row %0d is %b, expected %b", $time, r, got, exp);
        end
    endtask

    task automatic check_score(input logic [19:0] got, input logic [19:0] exp);
        if (got !== exp) begin
            err_value++;
            $display("FAILED %0t: score is %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_lines(input logic [2:0] got_cnt, input logic [9:0] got_total,
                               input logic [3:0] got_level);
        if (int'(got_cnt) != m_cnt || int'(got_total) != m_lines ||
            int'(got_level) != m_level) begin
            err_value++;
            $display("FAILED %0t: lines %0d total %0d level %0d, expected %0d %0d %0d",
                     $time, got_cnt, got_total, got_level, m_cnt, m_lines, m_level);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            err_value++;
            $display("FAILED %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic pulse(input int which);
        case (which)
            0: left = 1'b1;
            1: right = 1'b1;
            2: rotate = 1'b1;
            3: drop = 1'b1;
            default: start = 1'b1;
        endcase
        @(negedge pclk);
        left = 1'b0;
        right = 1'b0;
        rotate = 1'b0;
        drop = 1'b0;
        start = 1'b0;
    endtask

    task automatic check_all_rows();
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            row_sel = 5'(r);
            @(negedge pclk);
            check_row(r, row_bits, fld[r]);
        end
    endtask

    task automatic spawn_model();
        m_piece = m_next;
        m_next = take_piece();
        m_x = `SPAWN_X;
        m_y = 0;
        m_rot = 0;
        m_over = model_collide(m_piece, m_x, m_y, m_rot);
    endtask

    task automatic check_state();
        check_piece("piece", piece, m_piece);
        check_piece("next_piece", next_piece, m_next);
        check_pose(piece_x, piece_y, piece_rot);
        check_score(score, 20'(m_score));
        check_flag("game_over", game_over, m_over);
    endtask

    task automatic start_game();
        pulse(4);
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            fld[r] = '0;
        end
        m_score = 0;
        m_lines = 0;
        m_level = 0;
        m_cnt = 0;
        m_next = take_piece(); // first piece goes through next_piece
        spawn_model();
        @(negedge pclk);
        check_state();
        check_lines(lines_count, lines_total, level);
    endtask

    task automatic try_move(input int kind);
        int nx;
        int nrot;
        nx = m_x + ((kind == 0) ? -1 : (kind == 1) ? 1 : 0);
        nrot = (kind == 2) ? (m_rot + 1) % 4 : m_rot;
        pulse(kind);
        @(negedge pclk);
        if (!m_over && !model_collide(m_piece, nx, m_y, nrot)) begin
            m_x = nx;
            m_rot = nrot;
        end
        check_pose(piece_x, piece_y, piece_rot);
        @(negedge pclk);
    endtask

    task automatic finish_piece();
        int n;
        int off;
        n = 0;
        while (lock !== 1'b1 && n < 10) begin
            @(negedge pclk);
            n++;
        end
        if (lock !== 1'b1) begin
            err_timeout++;
            $display("timeout: lock never pulsed after a blocked fall");
            return;
        end
        for (int k = 0; k < 4; k++) begin
            off = cell_offset(m_piece, m_rot, k);
            fld[m_y + off % 4][m_x + off / 4] = 1'b1;
        end
        n = 0;
        while (lines_valid !== 1'b1 && n < 100) begin
            @(negedge pclk);
            n++;
        end
        if (lines_valid !== 1'b1) begin
            err_timeout++;
            $display("timeout: no lines_valid within 100 cycles after lock");
            return;
        end
        m_cnt = clear_rows();
        m_score = m_score + line_points(m_cnt) * (m_level + 1);
        m_lines = m_lines + m_cnt;
        m_level = (m_lines / `LEVEL_LINES > 9) ? 9 : m_lines / `LEVEL_LINES;
        repeat (2) @(negedge pclk); // spawn lands two cycles after lines_valid
        spawn_model();
        check_state();
        check_lines(lines_count, lines_total, level);
        check_all_rows();
    endtask

    task automatic drop_step(output logic locked);
        pulse(3);
        @(negedge pclk);
        if (model_collide(m_piece, m_x, m_y + 1, m_rot)) begin
            locked = 1'b1;
            finish_piece();
        end else begin
            locked = 1'b0;
            m_y++;
            m_score++;
            check_pose(piece_x, piece_y, piece_rot);
            check_score(score, 20'(m_score));
            @(negedge pclk);
        end
    endtask

    task automatic drop_to_lock();
        logic locked;
        int n;
        locked = 1'b0;
        n = 0;
        while (!locked && n < `BOARD_ROWS + 4) begin
            drop_step(locked);
            n++;
        end
        if (!locked) begin
            err_timeout++;
            $display("timeout: piece did not lock after %0d drops", n);
        end
    endtask

    task automatic wait_gravity_step();
        int n;
        n = 0;
        while (int'(piece_y) == m_y && n < `FALL_TICKS + 50) begin
            @(negedge pclk);
            n++;
        end
        if (int'(piece_y) == m_y) begin
            err_timeout++;
            $display("timeout: gravity did not move the piece");
            return;
        end
        if (!model_collide(m_piece, m_x, m_y + 1, m_rot))
            m_y++;
        check_pose(piece_x, piece_y, piece_rot);
    endtask

    initial begin
        int nmoves;
        int pcount;
        rng = 32'h82a8_3d4a;
        m_lfsr = `PIECE_SEED;
        err_value = 0;
        err_timeout = 0;
        m_over = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        left = 1'b0;
        right = 1'b0;
        drop = 1'b0;
        rotate = 1'b0;
        row_sel = '0;
        repeat (16) @(posedge pclk);
        @(negedge pclk);
        rst = 1'b0;
        repeat (5) begin
            @(negedge pclk);
            check_flag("lock", lock, 1'b0);
            check_flag("lines_valid", lines_valid, 1'b0);
            check_score(score, 20'd0);
        end

        start_game();
        wait_gravity_step();
        wait_gravity_step();

        for (int p = 0; p < 12 && !m_over; p++) begin
            nmoves = int'(next_rand() % 32'd8);
            for (int i = 0; i < nmoves; i++) begin
                try_move(int'(next_rand() % 32'd3));
            end
            drop_to_lock();
        end

        pcount = 0;
        while (!m_over && pcount < 60) begin // straight drops pile up at the spawn column
            drop_to_lock();
            pcount++;
        end
        if (!m_over) begin
            err_timeout++;
            $display("timeout: the game did not end after stacking %0d pieces", pcount);
        end

        try_move(0);
        try_move(2);
        pulse(3);
        repeat (3) @(negedge pclk);
        check_state();

        start_game();
        check_all_rows();
        try_move(1);
        drop_to_lock();

        $display("closing: %0d value errors, %0d timeouts", err_value, err_timeout);
        if (err_value == 0 && err_timeout == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- tetris.f
+incdir+verilog
verilog/tetris_pkg.sv
verilog/piece_shape.sv
verilog/board_store.sv
verilog/piece_ctl.sv
verilog/tetris_core.sv
tb/tetris_tb.sv

//--- verilog/board_store.sv
`timescale 1ns/1ps
`include "tetris_macros.svh"

module board_store (
    input  logic                   pclk,
    input  logic                   rst,
    input  logic                   clear_field,
    input  logic                   lock_req,
    input  logic signed [4:0]      cell_col0,
    input  logic signed [4:0]      cell_col1,
    input  logic signed [4:0]      cell_col2,
    input  logic signed [4:0]      cell_col3,
    input  logic [4:0]             cell_row0,
    input  logic [4:0]             cell_row1,
    input  logic [4:0]             cell_row2,
    input  logic [4:0]             cell_row3,
    input  logic [4:0]             row_sel,
    output logic                   collide,
    output logic                   clear_done,
    output logic [2:0]             clear_count,
    output logic [`BOARD_COLS-1:0] row_bits
);
    logic [`BOARD_COLS-1:0] rows [`BOARD_ROWS]; // row 0 is the top
    logic                   scan_on;
    logic [4:0]             scan_row;
    logic [2:0]             line_cnt;
    logic [3:0]             hit;

    function automatic logic cell_bad(input logic signed [4:0] col, input logic [4:0] row);
        logic outside;
        outside = (col < 0) || (col >= `BOARD_COLS) || (row >= `BOARD_ROWS);
        if (outside)
            cell_bad = 1'b1;
        else
            cell_bad = rows[row][col[3:0]];
    endfunction

    always_comb begin
        hit[0] = cell_bad(cell_col0, cell_row0);
        hit[1] = cell_bad(cell_col1, cell_row1);
        hit[2] = cell_bad(cell_col2, cell_row2);
        hit[3] = cell_bad(cell_col3, cell_row3);
        collide = |hit;
    end

    assign row_bits = (row_sel < `BOARD_ROWS) ? rows[row_sel] : '0;

    always_ff @(posedge pclk) begin
        if (rst || clear_field) begin
            for (int r = 0; r < `BOARD_ROWS; r++) begin
                rows[r] <= '0;
            end
            scan_on <= 1'b0;
            scan_row <= '0;
            line_cnt <= '0;
            clear_done <= 1'b0;
            clear_count <= '0;
        end else begin
            clear_done <= 1'b0;
            if (lock_req) begin
                rows[cell_row0][cell_col0[3:0]] <= 1'b1;
                rows[cell_row1][cell_col1[3:0]] <= 1'b1;
                rows[cell_row2][cell_col2[3:0]] <= 1'b1;
                rows[cell_row3][cell_col3[3:0]] <= 1'b1;
                scan_on <= 1'b1;
                scan_row <= 5'(`BOARD_ROWS - 1); // scan runs bottom up
                line_cnt <= '0;
            end else if (scan_on) begin
                if (&rows[scan_row]) begin
                    // collapse everything above, then look at the same row again
                    for (int r = `BOARD_ROWS - 1; r > 0; r--) begin
                        if (r <= scan_row)
                            rows[r] <= rows[r-1];
                    end
                    rows[0] <= '0;
                    line_cnt <= line_cnt + 3'd1;
                end else if (scan_row == 5'd0) begin
                    scan_on <= 1'b0;
                    clear_done <= 1'b1;
                    clear_count <= line_cnt;
                end else begin
                    scan_row <= scan_row - 5'd1;
                end
            end
        end
    end

    a_lock_no_scan: assert property (@(posedge pclk) disable iff (rst)
        lock_req |-> !scan_on);

    // the controller only locks a pose it has already found legal
    a_lock_free_cells: assert property (@(posedge pclk) disable iff (rst)
        lock_req |-> !collide);

endmodule

//--- verilog/piece_ctl.sv
`timescale 1ns/1ps
`include "tetris_macros.svh"

module piece_ctl (
    input  logic               pclk,
    input  logic               rst,
    input  logic               start,
    input  logic               left,
    input  logic               right,
    input  logic               drop,
    input  logic               rotate,
    input  logic               collide,
    input  logic               clear_done,
    input  logic [2:0]         clear_count,
    output tetris_pkg::piece_t cand_piece,
    output logic [1:0]         cand_rot,
    output logic signed [4:0]  cand_x,
    output logic [4:0]         cand_y,
    output logic               lock_req,
    output logic               clear_field,
    output tetris_pkg::piece_t piece,
    output tetris_pkg::piece_t next_piece,
    output logic signed [4:0]  piece_x,
    output logic [4:0]         piece_y,
    output logic [1:0]         piece_rot,
    output logic [19:0]        score,
    output logic [9:0]         lines_total,
    output logic [3:0]         level,
    output logic               game_over
);
    tetris_pkg::ctl_state_t state;
    tetris_pkg::piece_t     lfsr_piece;
    logic signed [4:0]      try_x;
    logic [4:0]             try_y;
    logic [1:0]             try_rot;
    logic                   try_fall; // trial is a move down, lock if it fails
    logic                   try_drop;
    logic [11:0]            grav_cnt;
    logic [11:0]            grav_period;
    logic                   grav_due;
    logic [15:0]            lfsr;
    logic [15:0]            lfsr_next;
    logic [10:0]            line_pts;
    logic [19:0]            clear_pts;
    logic [9:0]             lines_sum;
    logic [9:0]             level_raw;

    assign grav_period = 12'(`FALL_TICKS - `FALL_STEP * level);
    assign grav_due = grav_cnt >= grav_period - 12'd1;

    assign lfsr_next = lfsr[0] ? ((lfsr >> 1) ^ `LFSR_TAPS) : (lfsr >> 1);
    assign lfsr_piece = (lfsr_next[2:0] == 3'd7) ? tetris_pkg::PIECE_I
                                                  : tetris_pkg::piece_t'(lfsr_next[2:0]);

    always_comb begin
        case (clear_count)
            3'd1: line_pts = 11'd40;
            3'd2: line_pts = 11'd100;
            3'd3: line_pts = 11'd300;
            3'd4: line_pts = 11'd1200;
            default: line_pts = 11'd0;
        endcase
    end

    assign clear_pts = 20'(line_pts) * (20'(level) + 20'd1);
    assign lines_sum = lines_total + {7'd0, clear_count};
    assign level_raw = 10'(lines_sum / `LEVEL_LINES);

    assign lock_req = (state == tetris_pkg::ST_LOCK);
    assign clear_field = start && (state == tetris_pkg::ST_WAIT || state == tetris_pkg::ST_OVER);

    // the shape decoder sees the trial pose while one is being tested
    always_comb begin
        cand_piece = piece;
        cand_x = piece_x;
        cand_y = piece_y;
        cand_rot = piece_rot;
        if (state == tetris_pkg::ST_TRY) begin
            cand_x = try_x;
            cand_y = try_y;
            cand_rot = try_rot;
        end else if (state == tetris_pkg::ST_SPAWN) begin
            cand_piece = next_piece;
            cand_x = 5'(`SPAWN_X);
            cand_y = 5'd0;
            cand_rot = 2'd0;
        end
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            state <= tetris_pkg::ST_WAIT;
            lfsr <= `PIECE_SEED;
            piece <= tetris_pkg::PIECE_I;
            next_piece <= tetris_pkg::PIECE_I;
            piece_x <= 5'(`SPAWN_X);
            piece_y <= '0;
            piece_rot <= '0;
            try_x <= '0;
            try_y <= '0;
            try_rot <= '0;
            try_fall <= 1'b0;
            try_drop <= 1'b0;
            grav_cnt <= '0;
            score <= '0;
            lines_total <= '0;
            level <= '0;
            game_over <= 1'b0;
        end else begin
            case (state)
                tetris_pkg::ST_WAIT, tetris_pkg::ST_OVER: begin
                    if (start) begin
                        score <= '0;
                        lines_total <= '0;
                        level <= '0;
                        game_over <= 1'b0;
                        lfsr <= lfsr_next;
                        next_piece <= lfsr_piece; // spawn moves it into piece
                        state <= tetris_pkg::ST_SPAWN;
                    end
                end
                tetris_pkg::ST_IDLE: begin
                    try_x <= piece_x;
                    try_y <= piece_y;
                    try_rot <= piece_rot;
                    try_fall <= 1'b0;
                    try_drop <= drop;
                    if (left) begin
                        try_x <= piece_x - 5'sd1;
                        state <= tetris_pkg::ST_TRY;
                    end else if (right) begin
                        try_x <= piece_x + 5'sd1;
                        state <= tetris_pkg::ST_TRY;
                    end else if (rotate) begin
                        try_rot <= piece_rot + 2'd1;
                        state <= tetris_pkg::ST_TRY;
                    end else if (drop || grav_due) begin
                        try_y <= piece_y + 5'd1;
                        try_fall <= 1'b1;
                        state <= tetris_pkg::ST_TRY;
                    end else begin
                        grav_cnt <= grav_cnt + 12'd1;
                    end
                end
                tetris_pkg::ST_TRY: begin
                    if (!collide) begin
                        piece_x <= try_x;
                        piece_y <= try_y;
                        piece_rot <= try_rot;
                        if (try_fall)
                            grav_cnt <= '0;
                        if (try_fall && try_drop)
                            score <= score + 20'd1;
                    end
                    state <= (collide && try_fall) ? tetris_pkg::ST_LOCK : tetris_pkg::ST_IDLE;
                end
                tetris_pkg::ST_LOCK: begin
                    state <= tetris_pkg::ST_CLEAR;
                end
                tetris_pkg::ST_CLEAR: begin
                    if (clear_done) begin
                        score <= score + clear_pts;
                        lines_total <= lines_sum;
                        level <= (level_raw > 10'd9) ? 4'd9 : level_raw[3:0];
                        state <= tetris_pkg::ST_SPAWN;
                    end
                end
                tetris_pkg::ST_SPAWN: begin
                    piece <= next_piece;
                    next_piece <= lfsr_piece;
                    lfsr <= lfsr_next;
                    piece_x <= 5'(`SPAWN_X);
                    piece_y <= '0;
                    piece_rot <= '0;
                    grav_cnt <= '0;
                    if (collide) begin
                        game_over <= 1'b1; // held until the next start
                        state <= tetris_pkg::ST_OVER;
                    end else begin
                        state <= tetris_pkg::ST_IDLE;
                    end
                end
                default: state <= tetris_pkg::ST_WAIT;
            endcase
        end
    end

    // the row scan only ends while the controller is waiting for it
    a_clear_in_wait: assert property (@(posedge pclk) disable iff (rst)
        clear_done |-> state == tetris_pkg::ST_CLEAR);

    // a piece in play never overlaps a wall, the floor or a locked cell
    a_pose_legal: assert property (@(posedge pclk) disable iff (rst)
        state == tetris_pkg::ST_IDLE |-> !collide);

endmodule

//--- verilog/piece_shape.sv
`timescale 1ns/1ps

module piece_shape (
    input  tetris_pkg::piece_t cand_piece,
    input  logic [1:0]         cand_rot,
    input  logic signed [4:0]  cand_x,
    input  logic [4:0]         cand_y,
    output logic signed [4:0]  cell_col0,
    output logic signed [4:0]  cell_col1,
    output logic signed [4:0]  cell_col2,
    output logic signed [4:0]  cell_col3,
    output logic [4:0]         cell_row0,
    output logic [4:0]         cell_row1,
    output logic [4:0]         cell_row2,
    output logic [4:0]         cell_row3
);
    logic [15:0] offs; // four cells, each nibble is {col, row} inside the 4x4 box

    // rotation r+1 is the clockwise quarter turn of r
    always_comb begin
        case ({cand_piece, cand_rot})
            5'd0:  offs = 16'b0001_0101_1001_1101; // i
            5'd1:  offs = 16'b1000_1001_1010_1011;
            5'd2:  offs = 16'b0010_0110_1010_1110;
            5'd3:  offs = 16'b0100_0101_0110_0111;
            5'd4:  offs = 16'b0100_1000_0101_1001; // o looks the same in every rotation
            5'd5:  offs = 16'b0100_1000_0101_1001;
            5'd6:  offs = 16'b0100_1000_0101_1001;
            5'd7:  offs = 16'b0100_1000_0101_1001;
            5'd8:  offs = 16'b0100_0001_0101_1001; // t
            5'd9:  offs = 16'b0100_0101_1001_0110;
            5'd10: offs = 16'b0001_0101_1001_0110;
            5'd11: offs = 16'b0100_0001_0101_0110;
            5'd12: offs = 16'b0100_1000_0001_0101; // s
            5'd13: offs = 16'b0100_0101_1001_1010;
            5'd14: offs = 16'b0101_1001_0010_0110;
            5'd15: offs = 16'b0000_0001_0101_0110;
            5'd16: offs = 16'b0000_0100_0101_1001; // z
            5'd17: offs = 16'b1000_0101_1001_0110;
            5'd18: offs = 16'b0001_0101_0110_1010;
            5'd19: offs = 16'b0100_0001_0101_0010;
            5'd20: offs = 16'b0000_0001_0101_1001; // j
            5'd21: offs = 16'b0100_1000_0101_0110;
            5'd22: offs = 16'b0001_0101_1001_1010;
            5'd23: offs = 16'b0100_0101_0010_0110;
            5'd24: offs = 16'b1000_0001_0101_1001; // l
            5'd25: offs = 16'b0100_0101_0110_1010;
            5'd26: offs = 16'b0001_0101_1001_0010;
            5'd27: offs = 16'b0000_0100_0101_0110;
            default: offs = 16'b0000_0000_0000_0000;
        endcase
    end

    assign cell_col0 = cand_x + $signed({3'b000, offs[15:14]});
    assign cell_row0 = cand_y + {3'b000, offs[13:12]};
    assign cell_col1 = cand_x + $signed({3'b000, offs[11:10]});
    assign cell_row1 = cand_y + {3'b000, offs[9:8]};
    assign cell_col2 = cand_x + $signed({3'b000, offs[7:6]});
    assign cell_row2 = cand_y + {3'b000, offs[5:4]};
    assign cell_col3 = cand_x + $signed({3'b000, offs[3:2]});
    assign cell_row3 = cand_y + {3'b000, offs[1:0]};

endmodule

//--- verilog/tetris_core.sv
`timescale 1ns/1ps

module tetris_core (
    input  logic               pclk,
    input  logic               rst,
    input  logic               start,
    input  logic               left,
    input  logic               right,
    input  logic               drop,
    input  logic               rotate,
    input  logic [4:0]         row_sel,
    output tetris_pkg::piece_t piece,
    output tetris_pkg::piece_t next_piece,
    output logic signed [4:0]  piece_x,
    output logic [4:0]         piece_y,
    output logic [1:0]         piece_rot,
    output logic               lock,
    output logic               lines_valid,
    output logic [2:0]         lines_count,
    output logic [19:0]        score,
    output logic [9:0]         lines_total,
    output logic [3:0]         level,
    output logic               game_over,
    output logic [9:0]         row_bits
);
    tetris_pkg::piece_t cand_piece;
    logic [1:0]         cand_rot;
    logic signed [4:0]  cand_x;
    logic [4:0]         cand_y;
    logic signed [4:0]  cell_col0;
    logic signed [4:0]  cell_col1;
    logic signed [4:0]  cell_col2;
    logic signed [4:0]  cell_col3;
    logic [4:0]         cell_row0;
    logic [4:0]         cell_row1;
    logic [4:0]         cell_row2;
    logic [4:0]         cell_row3;
    logic               collide;
    logic               clear_field;

    piece_ctl i_piece_ctl (
        .*,
        .lock_req    (lock),
        .clear_done  (lines_valid),
        .clear_count (lines_count)
    );

    piece_shape i_piece_shape (.*);

    // lock and clear status go straight out to the renderer side too
    board_store i_board_store (
        .*,
        .lock_req    (lock),
        .clear_done  (lines_valid),
        .clear_count (lines_count)
    );

endmodule

//--- verilog/tetris_macros.svh
`ifndef TETRIS_MACROS_SVH
`define TETRIS_MACROS_SVH

// playfield size in cells
`define BOARD_COLS 10
`define BOARD_ROWS 20

`define SPAWN_X 3 // pose column of a fresh piece, row is always 0

// gravity period in clock cycles, shortened per level
`define FALL_TICKS 2000
`define FALL_STEP 150
`define LEVEL_LINES 10

// galois lfsr for the piece sequence
`define PIECE_SEED 16'hACE1
`define LFSR_TAPS 16'hB400

`endif

//--- verilog/tetris_pkg.sv
package tetris_pkg;

    typedef enum logic [2:0] {
        PIECE_I = 3'd0,
        PIECE_O = 3'd1,
        PIECE_T = 3'd2,
        PIECE_S = 3'd3,
        PIECE_Z = 3'd4,
        PIECE_J = 3'd5,
        PIECE_L = 3'd6
    } piece_t;

    typedef enum logic [2:0] {
        ST_WAIT,  // before the first start
        ST_IDLE,  // piece falling, strobes accepted
        ST_TRY,   // candidate pose checked against the field
        ST_LOCK,  // piece written into the field
        ST_CLEAR, // waiting for the row scan
        ST_SPAWN, // next piece brought in
        ST_OVER
    } ctl_state_t;

endpackage
